// ==== edge_job_control.f ====
logic/edge_job_pkg.sv
logic/sync_fifo.sv
logic/edge_read_planner.sv
logic/edge_line_unpacker.sv
logic/edge_job_control.sv
verif/tb_edge_job_control.sv

// ==== logic/edge_job_control.sv ====
////////////////////////////////////////////////////////////////////////////
// edge fetch top level
// planner, read command queue, line unpacker and edge job queue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_job_control
	import edge_job_pkg::*;
(
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   vertex_valid,
	output logic                   vertex_ready,
	input  logic [vertex_bits-1:0] vertex_id,
	input  logic [count_bits-1:0]  vertex_edge_index,
	input  logic [count_bits-1:0]  vertex_degree,
	input  logic [addr_bits-1:0]   edge_array_base,
	output logic                   cmd_request,
	input  logic                   cmd_grant,
	output logic                   cmd_valid,
	output read_cmd_t              cmd_out,
	input  logic                   line_valid,
	input  logic [line_bits-1:0]   line_data,
	input  logic [slot_bits:0]     line_count,
	input  logic [slot_bits-1:0]   line_offset,
	input  logic                   edge_request,
	output logic                   edge_valid,
	output edge_job_t              edge_out,
	output logic                   edge_empty
);

	logic                      cmd_push;
	read_cmd_t                 cmd_data;
	logic                      cmd_fifo_empty;
	logic [edge_room_bits-1:0] edge_fifo_free;
	logic [vertex_bits-1:0]    cur_vertex_id;
	logic                      vertex_start;
	logic                      edge_push;
	edge_job_t                 edge_data;
	logic                      line_done;

	// bus request stays up while a command waits
	assign cmd_request = !cmd_fifo_empty;

	edge_read_planner u_planner (
		.clock             (clock),
		.rstn              (rstn),
		.vertex_valid      (vertex_valid),
		.vertex_id         (vertex_id),
		.vertex_edge_index (vertex_edge_index),
		.vertex_degree     (vertex_degree),
		.edge_array_base   (edge_array_base),
		.cmd_fifo_empty    (cmd_fifo_empty),
		.edge_fifo_room    (edge_fifo_free),
		.line_done         (line_done),
		.vertex_ready      (vertex_ready),
		.cmd_push          (cmd_push),
		.cmd_data          (cmd_data),
		.cur_vertex_id     (cur_vertex_id),
		.vertex_start      (vertex_start)
	);

	sync_fifo #(
		.payload_t (read_cmd_t),
		.depth     (cmd_fifo_depth)
	) u_cmd_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (cmd_push),
		.push_data  (cmd_data),
		.pop        (cmd_grant),
		.pop_valid  (cmd_valid),
		.pop_data   (cmd_out),
		.empty      (cmd_fifo_empty),
		.free_count ()
	);

	edge_line_unpacker u_unpacker (
		.clock         (clock),
		.rstn          (rstn),
		.line_valid    (line_valid),
		.line_data     (line_data),
		.line_count    (line_count),
		.line_offset   (line_offset),
		.cur_vertex_id (cur_vertex_id),
		.vertex_start  (vertex_start),
		.edge_push     (edge_push),
		.edge_data     (edge_data),
		.line_done     (line_done)
	);

	sync_fifo #(
		.payload_t (edge_job_t),
		.depth     (edge_fifo_depth)
	) u_edge_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (edge_push),
		.push_data  (edge_data),
		.pop        (edge_request),
		.pop_valid  (edge_valid),
		.pop_data   (edge_out),
		.empty      (edge_empty),
		.free_count (edge_fifo_free)
	);

endmodule

// ==== logic/edge_job_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// widths, cacheline geometry and queue depths for the edge fetch path
// read command and edge job records
// planner state encoding
////////////////////////////////////////////////////////////////////////////

package edge_job_pkg;

	// byte addressing and edge entries
	localparam int addr_bits   = 64;
	localparam int edge_bits   = 32;
	localparam int edge_bytes  = 4;
	localparam int count_bits  = 32;
	localparam int vertex_bits = 32;

	// cacheline geometry, slot 0 is the least significant word
	localparam int line_bytes    = 64;
	localparam int line_bits     = line_bytes * 8;
	localparam int line_edges    = line_bytes / edge_bytes;
	localparam int slot_bits     = $clog2(line_edges);
	localparam int line_off_bits = $clog2(line_bytes);
	localparam int edge_off_bits = $clog2(edge_bytes);

	// queue depths
	localparam int cmd_fifo_depth  = 16;
	localparam int edge_fifo_depth = 32;
	localparam int edge_room_bits  = $clog2(edge_fifo_depth + 1);

	// one line read, address is line aligned
	typedef struct packed {
		logic [addr_bits-1:0] address;
		logic [slot_bits:0]   edge_count;
		logic [slot_bits-1:0] line_offset;
	} read_cmd_t;

	// edge job handed to the consumer
	typedef struct packed {
		logic [count_bits-1:0]  id;
		logic [vertex_bits-1:0] src;
		logic [edge_bits-1:0]   dest;
	} edge_job_t;

	typedef enum logic [1:0] {
		plan_idle,
		plan_check,
		plan_wait
	} planner_state_t;

endpackage

// ==== logic/edge_line_unpacker.sv ====
////////////////////////////////////////////////////////////////////////////
// capture of a returned cacheline
// one byte-swapped edge entry per cycle, tagged with src and edge id
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_line_unpacker
	import edge_job_pkg::*;
(
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   line_valid,
	input  logic [line_bits-1:0]   line_data,
	input  logic [slot_bits:0]     line_count,
	input  logic [slot_bits-1:0]   line_offset,
	input  logic [vertex_bits-1:0] cur_vertex_id,
	input  logic                   vertex_start,
	output logic                   edge_push,
	output edge_job_t              edge_data,
	output logic                   line_done
);

	logic [line_bits-1:0]  line_aligned;
	logic [line_bits-1:0]  line_shift;
	logic [slot_bits:0]    left;
	logic [count_bits-1:0] edge_id;
	logic [edge_bits-1:0]  slot_word;

	// first used slot moved down to slot 0
	assign line_aligned = line_data >> (int'(line_offset) * edge_bits);

	assign slot_word = line_shift[edge_bits-1:0];
	assign edge_push = (left != '0);

	assign edge_data.id   = edge_id;
	assign edge_data.src  = cur_vertex_id;
	// byte order reversed
	assign edge_data.dest = {slot_word[7:0], slot_word[15:8], slot_word[23:16], slot_word[31:24]};

	////////////////////////////////////////////////////////////////////////////
	// entry count, edge numbering and end of line
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			left      <= '0;
			edge_id   <= '0;
			line_done <= 1'b0;
		end else begin
			// last entry goes out while left is one
			line_done <= (left == (slot_bits+1)'(1));
			if (line_valid)
				left <= line_count;
			else if (edge_push)
				left <= left - 1'b1;
			// ids run across all lines of one vertex
			if (vertex_start)
				edge_id <= '0;
			else if (edge_push)
				edge_id <= edge_id + 1'b1;
		end
	end

	// line shift register
	always_ff @(posedge clock) begin
		if (line_valid)
			line_shift <= line_aligned;
		else if (edge_push)
			line_shift <= line_shift >> edge_bits;
	end

endmodule

// ==== logic/edge_read_planner.sv ====
////////////////////////////////////////////////////////////////////////////
// vertex acceptance and slice bookkeeping
// one cacheline read command per line touched by the vertex's edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_read_planner
	import edge_job_pkg::*;
(
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      vertex_valid,
	input  logic [vertex_bits-1:0]    vertex_id,
	input  logic [count_bits-1:0]     vertex_edge_index,
	input  logic [count_bits-1:0]     vertex_degree,
	input  logic [addr_bits-1:0]      edge_array_base,
	input  logic                      cmd_fifo_empty,
	input  logic [edge_room_bits-1:0] edge_fifo_room,
	input  logic                      line_done,
	output logic                      vertex_ready,
	output logic                      cmd_push,
	output read_cmd_t                 cmd_data,
	output logic [vertex_bits-1:0]    cur_vertex_id,
	output logic                      vertex_start
);

	planner_state_t          state;
	logic [count_bits-1:0]   remaining;
	logic [addr_bits-1:0]    byte_offset;
	logic [addr_bits-1:0]    aligned;
	logic [slot_bits-1:0]    first_slot;
	logic [slot_bits:0]      line_room;
	logic [slot_bits:0]      take;
	logic                    issue;

	assign vertex_ready = (state == plan_idle);
	assign vertex_start = vertex_valid && vertex_ready;

	////////////////////////////////////////////////////////////////////////////
	// alignment and remainder of the current offset
	////////////////////////////////////////////////////////////////////////////

	assign aligned    = byte_offset & ~addr_bits'(line_bytes - 1);
	assign first_slot = byte_offset[line_off_bits-1:edge_off_bits];
	assign line_room  = (slot_bits+1)'(line_edges) - {1'b0, first_slot};

	// entries taken from this line
	assign take = (remaining < count_bits'(line_room)) ? remaining[slot_bits:0] : line_room;

	// empty command queue and room for a whole line of edges
	assign issue = (state == plan_check) && (remaining != '0) && cmd_fifo_empty &&
		(edge_fifo_room >= edge_room_bits'(line_edges));

	////////////////////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= plan_idle;
			remaining <= '0;
			cmd_push  <= 1'b0;
		end else begin
			cmd_push <= issue;
			case (state)
				plan_idle: begin
					if (vertex_start) begin
						remaining <= vertex_degree;
						state     <= plan_check;
					end
				end
				plan_check: begin
					// degree zero ends here without a read
					if (remaining == '0) begin
						state <= plan_idle;
					end else if (issue) begin
						remaining <= remaining - count_bits'(take);
						state     <= plan_wait;
					end
				end
				plan_wait: begin
					// one read in flight, next line only after this one is unpacked
					if (line_done)
						state <= (remaining == '0) ? plan_idle : plan_check;
				end
				default: begin
					state <= plan_idle;
				end
			endcase
		end
	end

	// vertex latch, offset walk and command word
	always_ff @(posedge clock) begin
		if (vertex_start) begin
			cur_vertex_id <= vertex_id;
			byte_offset   <= addr_bits'(vertex_edge_index) << edge_off_bits;
		end
		if (issue) begin
			cmd_data.address     <= edge_array_base + aligned;
			cmd_data.edge_count  <= take;
			cmd_data.line_offset <= first_slot;
			// next read starts on the following line boundary
			byte_offset          <= aligned + addr_bits'(line_bytes);
		end
	end

endmodule

// ==== logic/sync_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// synchronous FIFO, circular buffer with registered pop output
// payload given as a type parameter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 16
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  payload_t                     push_data,
	input  logic                         pop,
	output logic                         pop_valid,
	output payload_t                     pop_data,
	output logic                         empty,
	output logic [$clog2(depth+1)-1:0]   free_count
);

	payload_t                     mem [depth];
	logic [$clog2(depth)-1:0]     wr_ptr;
	logic [$clog2(depth)-1:0]     rd_ptr;
	logic [$clog2(depth+1)-1:0]   count;
	logic                         push_ok;
	logic                         pop_ok;

	// pops on an empty queue are dropped
	assign push_ok    = push && (count != ($clog2(depth+1))'(depth));
	assign pop_ok     = pop && !empty;
	assign empty      = (count == '0);
	assign free_count = ($clog2(depth+1))'(depth) - count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= pop_ok;
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
		end
	end

	// storage and output word
	always_ff @(posedge clock) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
		if (pop_ok)
			pop_data <= mem[rd_ptr];
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the edge fetch testbench with Verilator
# the run counts as failed when the log holds the fail line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=sim_edge_job_control

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_edge_job_control \
	-f edge_job_control.f \
	--Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
	echo "verilator compile step returned an error"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q ">>> FAIL" "$log_file"; then
	echo "simulation reported a failure, see $log_file"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

echo "simulation finished without errors"
exit 0

// ==== verif/tb_edge_job_control.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the edge fetch top level
// clock, reset, LFSR driven memory model and grant source
// slice rule scoreboard, pop timing assertions and timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_edge_job_control
	import edge_job_pkg::*;
();

	// five vertices of at most 40 edges take well under 200 cycles each
	localparam int cycle_limit = 20000;
	localparam logic [addr_bits-1:0] base_addr = 64'h0000_0040_0001_0000;

	logic                   clock = 1'b0;
	logic                   rstn;
	logic                   vertex_valid;
	logic                   vertex_ready;
	logic [vertex_bits-1:0] vertex_id;
	logic [count_bits-1:0]  vertex_edge_index;
	logic [count_bits-1:0]  vertex_degree;
	logic [addr_bits-1:0]   edge_array_base;
	logic                   cmd_request;
	logic                   cmd_grant;
	logic                   cmd_valid;
	read_cmd_t              cmd_out;
	logic                   line_valid;
	logic [line_bits-1:0]   line_data;
	logic [slot_bits:0]     line_count;
	logic [slot_bits-1:0]   line_offset;
	logic                   edge_request;
	logic                   edge_valid;
	edge_job_t              edge_out;
	logic                   edge_empty;

	logic [31:0]            lfsr_state = 32'hfc3b_c644;
	int unsigned            cycle_count = 0;
	int                     delivered = 0;
	int                     popped = 0;
	logic                   drain = 1'b0;
	string                  test_name = "reset";
	string                  vertex_test [8];
	read_cmd_t              exp_cmds [$];
	edge_job_t              exp_jobs [8][$];

	edge_job_control u_dut (.*);

	always #4 clock = ~clock;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp_v,
		input logic [127:0] act_v);
		stop_on_error($sformatf("FAILED %s expected %0h actual %0h", name, exp_v, act_v));
	endtask

	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output int unsigned value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// memory contents and expected traffic
	////////////////////////////////////////////////////////////////////////////

	// both address halves folded into the word
	function automatic logic [31:0] mem_word(input logic [addr_bits-1:0] a);
		return a[63:32] ^ a[31:0] ^ 32'h5a5a_0000;
	endfunction

	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++)
			r[b*8 +: 8] = w[(3-b)*8 +: 8];
		return r;
	endfunction

	function automatic logic [line_bits-1:0] fill_line(input logic [addr_bits-1:0] addr);
		logic [line_bits-1:0] line;
		line = '0;
		for (int k = 0; k < line_edges; k++)
			line[k*edge_bits +: edge_bits] = mem_word(addr + addr_bits'(k * edge_bytes));
		return line;
	endfunction

	task automatic plan_vertex(input int id, input int index, input int degree);
		int        off;
		int        left;
		int        slot;
		int        cnt;
		read_cmd_t c;
		edge_job_t j;
		off = index * edge_bytes;
		left = degree;
		while (left > 0) begin
			slot = (off % line_bytes) / edge_bytes;
			cnt = (left < line_edges - slot) ? left : line_edges - slot;
			c.address = base_addr + addr_bits'(off - off % line_bytes);
			c.edge_count = (slot_bits+1)'(cnt);
			c.line_offset = slot_bits'(slot);
			exp_cmds.push_back(c);
			left = left - cnt;
			off = off - off % line_bytes + line_bytes;
		end
		for (int i = 0; i < degree; i++) begin
			j.id = count_bits'(i);
			j.src = vertex_bits'(id);
			j.dest = swap_bytes(mem_word(base_addr + addr_bits'((index + i) * edge_bytes)));
			exp_jobs[id].push_back(j);
		end
	endtask

	function automatic bit all_drained();
		for (int v = 0; v < 8; v++)
			if (exp_jobs[v].size() != 0)
				return 1'b0;
		return exp_cmds.size() == 0;
	endfunction

	task automatic send_vertex(input string name, input int id, input int index,
		input int degree);
		test_name = name;
		vertex_test[id] = name;
		plan_vertex(id, index, degree);
		@(posedge clock);
		while (!vertex_ready)
			@(posedge clock);
		#1;
		vertex_valid = 1'b1;
		vertex_id = vertex_bits'(id);
		vertex_edge_index = count_bits'(index);
		vertex_degree = count_bits'(degree);
		@(posedge clock);
		#1 vertex_valid = 1'b0;
	endtask

	task automatic wait_ready();
		@(posedge clock);
		while (!vertex_ready)
			@(posedge clock);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus models
	////////////////////////////////////////////////////////////////////////////

	// grant after 0 to 3 cycles
	initial begin : grant_source
		int unsigned gap;
		forever begin
			@(posedge clock);
			if (rstn && cmd_request) begin
				draw_bits(2, gap);
				repeat (gap) @(posedge clock);
				#1 cmd_grant = 1'b1;
				@(posedge clock);
				#1 cmd_grant = 1'b0;
			end
		end
	end

	// line answer 3 to 10 cycles after cmd_valid
	initial begin : memory_model
		read_cmd_t   req;
		int unsigned wait_cycles;
		forever begin
			@(posedge clock);
			if (cmd_valid) begin
				req = cmd_out;
				draw_bits(3, wait_cycles);
				repeat (wait_cycles + 2) @(posedge clock);
				#1;
				line_data = fill_line(req.address);
				line_count = req.edge_count;
				line_offset = req.line_offset;
				line_valid = 1'b1;
				@(posedge clock);
				#1 line_valid = 1'b0;
			end
		end
	end

	// consumer pops on random cycles and sometimes while empty
	always @(posedge clock) begin : consumer
		int unsigned coin;
		#1;
		draw_bits(1, coin);
		edge_request = drain && coin[0];
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			stop_on_error("timeout, the tests did not finish within the cycle limit");
	end

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstn)
		(edge_request && !edge_empty) |=> edge_valid)
		else stop_on_error("edge_valid missing one cycle after an accepted edge_request");
	assert property (@(posedge clock) disable iff (!rstn)
		!(edge_request && !edge_empty) |=> !edge_valid)
		else stop_on_error("edge_valid without an accepted edge_request");
	assert property (@(posedge clock) disable iff (!rstn)
		(cmd_grant && cmd_request) |=> cmd_valid)
		else stop_on_error("cmd_valid missing one cycle after cmd_grant");
	assert property (@(posedge clock) disable iff (!rstn)
		!(cmd_grant && cmd_request) |=> !cmd_valid)
		else stop_on_error("cmd_valid without a cmd_grant");

	always @(posedge clock) begin : scoreboard
		read_cmd_t exp_cmd;
		edge_job_t exp_job;
		if (rstn) begin
			if (line_valid)
				delivered = delivered + int'(line_count);
			if (edge_request && !edge_empty)
				popped = popped + 1;
			assert (delivered - popped <= edge_fifo_depth)
				else stop_on_error("more edge jobs queued than the edge queue holds");
			if (cmd_valid) begin
				assert (exp_cmds.size() != 0)
					else stop_on_error("read command that no vertex slice calls for");
				exp_cmd = exp_cmds.pop_front();
				assert (cmd_out == exp_cmd)
					else report_mismatch(test_name, exp_cmd, cmd_out);
				assert (delivered - popped + int'(cmd_out.edge_count) <= edge_fifo_depth)
					else stop_on_error("read command issued without room for its line");
			end
			if (edge_valid) begin
				assert (edge_out.src < 8 && exp_jobs[edge_out.src[2:0]].size() != 0)
					else stop_on_error("edge job from a vertex with no jobs pending");
				exp_job = exp_jobs[edge_out.src[2:0]].pop_front();
				assert (edge_out == exp_job)
					else report_mismatch(vertex_test[edge_out.src[2:0]], exp_job, edge_out);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rstn = 1'b0;
		vertex_valid = 1'b0;
		vertex_id = '0;
		vertex_edge_index = '0;
		vertex_degree = '0;
		edge_array_base = base_addr;
		cmd_grant = 1'b0;
		line_valid = 1'b0;
		line_data = '0;
		line_count = '0;
		line_offset = '0;
		edge_request = 1'b0;
		repeat (8) @(posedge clock);
		#1 rstn = 1'b1;

		@(posedge clock);
		assert ({vertex_ready, edge_empty, cmd_request, cmd_valid, edge_valid} == 5'b11000)
			else report_mismatch("reset", 5'b11000,
				{vertex_ready, edge_empty, cmd_request, cmd_valid, edge_valid});
		drain = 1'b1;

		// jobs of the first vertex may still sit queued during the second
		send_vertex("aligned", 1, 32, 16);
		wait_ready();
		send_vertex("misaligned", 2, 13, 25);
		wait_ready();

		send_vertex("degree zero", 3, 7, 0);
		@(posedge clock);
		assert (!vertex_ready && !cmd_request)
			else stop_on_error("degree zero vertex: not busy on the cycle after acceptance");
		@(posedge clock);
		assert (vertex_ready && !cmd_request)
			else stop_on_error("degree zero vertex: vertex_ready not back after 2 cycles");

		while (!all_drained())
			@(posedge clock);
		drain = 1'b0;
		send_vertex("back pressure", 4, 64, 40);
		while (delivered - popped != edge_fifo_depth)
			@(posedge clock);
		repeat (40) @(posedge clock);
		assert (exp_cmds.size() == 1 && !cmd_request && !vertex_ready)
			else stop_on_error("back pressure: read issued while the edge queue was full");
		drain = 1'b1;
		wait_ready();

		send_vertex("mixed traffic", 5, 203, 37);
		wait_ready();

		while (!all_drained())
			@(posedge clock);
		@(posedge clock);
		if (edge_empty) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stop_on_error("edge queue not empty after all expected jobs arrived");
		end
	end

endmodule
